// ==== filelist.f ====
+incdir+verilog
verilog/rvv_pkg.sv
verilog/vmul_pkg.sv
verilog/vmul_vinsn_queue.sv
verilog/vmul_issue.sv
verilog/vmul_simd_mul.sv
verilog/vmul_commit.sv
verilog/vmul_top.sv
sim/vmul_chk.sv
sim/vmul_scoreboard.sv
sim/vmul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module vmul_tb \
  -f filelist.f -o vmul_sim
./obj_dir/vmul_sim +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q "all tests passed" sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== sim/vmul_tb.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_clk_gen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

module vmul_tb import rvv_pkg::*; import vmul_pkg::*; ();

  localparam int NUM_ROWS    = 20;
  localparam int DRIVE_DELAY = 1;
  localparam int WAIT_LIMIT  = 200;
  localparam int DONE_LIMIT  = 4000;

  logic                    clk_i, rst_ni;
  vinsn_t                  vinsn_i;
  logic                    vinsn_valid_i, vinsn_ready_o;
  logic [2:0][`ELEN-1:0]   operand_i;
  logic [2:0]              operand_valid_i, operand_ready_o;
  logic                    result_req_o;
  vid_t                    result_id_o;
  logic [`VADDR_WIDTH-1:0] result_addr_o;
  logic [`ELEN-1:0]        result_wdata_o;
  logic [`ELEN/8-1:0]      result_be_o;
  logic                    result_gnt_i;
  logic [`NR_VINSN-1:0]    vinsn_done_o;

  vinsn_t      stim [NUM_ROWS];
  logic [31:0] lfsr_state = 32'h5396_0fe5;
  logic [2:0]  opnd_taken = '0;
  logic        timed_out;
  int          error_count, write_count, done_count;

  vmul_clk_gen vmul_clk_gen_inst (.clk_o(clk_i), .rst_no(rst_ni));

  vmul_top vmul_top_inst (.*);

  vmul_scoreboard vmul_scoreboard_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (vinsn_i),
    .vinsn_valid_i   (vinsn_valid_i),
    .vinsn_ready_i   (vinsn_ready_o),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_i (operand_ready_o),
    .result_req_i    (result_req_o),
    .result_id_i     (result_id_o),
    .result_addr_i   (result_addr_o),
    .result_wdata_i  (result_wdata_o),
    .result_be_i     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_i    (vinsn_done_o),
    .error_count_o   (error_count),
    .write_count_o   (write_count),
    .done_count_o    (done_count)
  );

  bind vmul_top vmul_chk vmul_chk_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .operand_valid_i (operand_valid_i),
    .operand_ready_i (operand_ready_o),
    .result_req_i    (result_req_o),
    .result_id_i     (result_id_o),
    .result_addr_i   (result_addr_o),
    .result_wdata_i  (result_wdata_o),
    .result_be_i     (result_be_o),
    .result_gnt_i    (result_gnt_i),
    .vinsn_done_i    (vinsn_done_o)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic vinsn_t make_insn(input vmul_op_e op, input vew_e vsew, input int vl,
                                       input int vd, input int id, input logic use_scalar,
                                       input logic [63:0] scalar);
    vinsn_t v;
    v.op         = op;
    v.vsew       = vsew;
    v.vl         = `VL_WIDTH'(vl);
    v.vd         = 5'(vd);
    v.id         = vid_t'(id);
    v.use_scalar = use_scalar;
    v.scalar_op  = scalar;
    return v;
  endfunction

  task automatic fill_table();
    // Plain products at each width, lengths in whole words
    stim[0]  = make_insn(VMUL,  EW8,  16, 1,  0, 1'b0, 64'h0);
    stim[1]  = make_insn(VMUL,  EW16, 8,  2,  1, 1'b0, 64'h0);
    stim[2]  = make_insn(VMUL,  EW32, 4,  3,  2, 1'b0, 64'h0);
    stim[3]  = make_insn(VMUL,  EW64, 2,  4,  3, 1'b0, 64'h0);
    stim[4]  = make_insn(VMULH, EW8,  8,  5,  4, 1'b0, 64'h0);
    stim[5]  = make_insn(VMULH, EW16, 12, 6,  5, 1'b0, 64'h0);
    stim[6]  = make_insn(VMULH, EW32, 4,  7,  6, 1'b0, 64'h0);
    stim[7]  = make_insn(VMULH, EW64, 3,  8,  7, 1'b0, 64'h0);
    stim[8]  = make_insn(VMACC, EW8,  16, 9,  0, 1'b0, 64'h0);
    stim[9]  = make_insn(VMACC, EW16, 4,  10, 1, 1'b0, 64'h0);
    stim[10] = make_insn(VMACC, EW32, 6,  11, 2, 1'b0, 64'h0);
    stim[11] = make_insn(VMACC, EW64, 2,  12, 3, 1'b0, 64'h0);
    // Scalars carry junk above the element width
    stim[12] = make_insn(VMUL,  EW8,  8,  13, 4, 1'b1, 64'h1234_5678_9abc_def3);
    stim[13] = make_insn(VMACC, EW16, 8,  14, 5, 1'b1, 64'hdead_beef_0000_8001);
    stim[14] = make_insn(VMULH, EW32, 4,  15, 6, 1'b1, 64'h5555_aaaa_7fff_ffff);
    stim[15] = make_insn(VMUL,  EW64, 2,  16, 7, 1'b1, 64'hffff_ffff_ffff_fffd);
    // Partial last words
    stim[16] = make_insn(VMUL,  EW8,  13, 17, 0, 1'b0, 64'h0);
    stim[17] = make_insn(VMACC, EW16, 6,  18, 1, 1'b0, 64'h0);
    stim[18] = make_insn(VMULH, EW32, 3,  19, 2, 1'b0, 64'h0);
    stim[19] = make_insn(VMUL,  EW8,  1,  30, 3, 1'b0, 64'h0);
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!rst_ni && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!rst_ni) begin
      timed_out = 1'b1;
      $display("Timeout: reset was never released");
    end
  endtask

  // Valid stays high from row to row, so instructions go back to back
  task automatic send_insn(input vinsn_t v);
    int cycles;
    cycles = 0;
    vinsn_i       = v;
    vinsn_valid_i = 1'b1;
    while (!vinsn_ready_o && cycles < WAIT_LIMIT) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      cycles++;
    end
    if (!vinsn_ready_o) begin
      timed_out = 1'b1;
      $display("Timeout: instruction id %0d was never accepted", v.id);
    end else begin
      @(posedge clk_i);
      #DRIVE_DELAY;
    end
  endtask

  task automatic wait_all_done();
    int cycles;
    cycles = 0;
    vinsn_valid_i = 1'b0;
    while (done_count < NUM_ROWS && cycles < DONE_LIMIT) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      cycles++;
    end
    if (done_count < NUM_ROWS) begin
      timed_out = 1'b1;
      $display("Timeout: only %0d of %0d instructions finished", done_count, NUM_ROWS);
    end
  endtask

  always @(negedge clk_i) begin
    opnd_taken = operand_ready_o & operand_valid_i;
  end

  // Operand queues refill after a word is taken, grant stalls at random
  always @(posedge clk_i) begin
    #DRIVE_DELAY;
    if (rst_ni) begin
      for (int p = 0; p < 3; p++) begin
        if (!operand_valid_i[p] || opnd_taken[p]) begin
          operand_valid_i[p] = |rand_bits(2);
          operand_i[p]       = rand_bits(64);
        end
      end
      result_gnt_i = |rand_bits(2);
    end
  end

  initial begin
    int total;
    vinsn_i         = '0;
    vinsn_valid_i   = 1'b0;
    operand_i       = '0;
    operand_valid_i = '0;
    result_gnt_i    = 1'b0;
    timed_out       = 1'b0;
    fill_table();
    wait_reset_release();
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (!timed_out) send_insn(stim[r]);
    end
    if (!timed_out) wait_all_done();
    total = error_count + vmul_top_inst.vmul_chk_inst.fail_count;
    $display("Checked %0d writes and %0d done pulses, %0d compare errors, %0d assertion failures",
             write_count, done_count, error_count, vmul_top_inst.vmul_chk_inst.fail_count);
    if (!timed_out && total == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== sim/vmul_scoreboard.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_scoreboard import rvv_pkg::*; import vmul_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vinsn_t                  vinsn_i,
  input  logic                    vinsn_valid_i,
  input  logic                    vinsn_ready_i,
  input  logic [2:0][`ELEN-1:0]   operand_i,
  input  logic [2:0]              operand_valid_i,
  input  logic [2:0]              operand_ready_i,
  input  logic                    result_req_i,
  input  vid_t                    result_id_i,
  input  logic [`VADDR_WIDTH-1:0] result_addr_i,
  input  logic [`ELEN-1:0]        result_wdata_i,
  input  logic [`ELEN/8-1:0]      result_be_i,
  input  logic                    result_gnt_i,
  input  logic [`NR_VINSN-1:0]    vinsn_done_i,
  output int                      error_count_o,
  output int                      write_count_o,
  output int                      done_count_o
);

  typedef struct packed {
    logic [15:0]             insn;
    logic [7:0]              word;
    vid_t                    id;
    logic [`VADDR_WIDTH-1:0] addr;
    logic [`ELEN-1:0]        wdata;
    logic [`ELEN/8-1:0]      be;
    logic                    last;
  } exp_write_t;

  vinsn_t     pending_q [$];
  exp_write_t exp_q [$];
  int         issued_elems = 0;
  int         insn_idx = 0;
  int         in_flight = 0;

  initial begin
    error_count_o = 0;
    write_count_o = 0;
    done_count_o  = 0;
  end

  function automatic logic [63:0] element_mask(input int bits);
    return (bits >= 64) ? '1 : (64'd1 << bits) - 64'd1;
  endfunction

  function automatic logic signed [127:0] sign_extend(input logic [63:0] v, input int bits);
    logic signed [127:0] t;
    t = {64'd0, v};
    t = t << (128 - bits);
    return t >>> (128 - bits);
  endfunction

  function automatic logic [63:0] replicate_scalar(input logic [63:0] s, input vew_e vsew);
    int          ebits;
    logic [63:0] r;
    ebits = 8 << int'(vsew);
    r = '0;
    for (int k = 0; k < 64 / ebits; k++) begin
      r = r | ((s & element_mask(ebits)) << (k * ebits));
    end
    return r;
  endfunction

  // Element-wise reference on full-width signed products
  function automatic logic [63:0] expected_word(input vmul_op_e op, input vew_e vsew,
                                                input logic [63:0] a, input logic [63:0] b,
                                                input logic [63:0] c);
    int                  ebits;
    logic [63:0]         mask;
    logic [63:0]         res;
    logic signed [127:0] prod;
    logic [127:0]        elem;
    ebits = 8 << int'(vsew);
    mask  = element_mask(ebits);
    res   = '0;
    for (int k = 0; k < 64 / ebits; k++) begin
      prod = sign_extend((a >> (k * ebits)) & mask, ebits) *
             sign_extend((b >> (k * ebits)) & mask, ebits);
      case (op)
        VMULH:   elem = prod >>> ebits;
        VMACC:   elem = prod + {64'd0, (c >> (k * ebits)) & mask};
        default: elem = prod;
      endcase
      res = res | ((64'(elem) & mask) << (k * ebits));
    end
    return res;
  endfunction

  function automatic logic [`ELEN/8-1:0] byte_enables(input int nbytes);
    logic [`ELEN/8-1:0] be;
    for (int j = 0; j < `ELEN / 8; j++) begin
      be[j] = (j < nbytes);
    end
    return be;
  endfunction

  task automatic compare(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
    if (actual !== expected) begin
      error_count_o++;
      $display("Error %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // One word issues whenever vs2 is consumed
  task automatic predict_word();
    vinsn_t      cur;
    int          epw;
    int          live;
    logic [63:0] op_a;
    exp_write_t  e;
    if (pending_q.size() == 0) begin
      error_count_o++;
      $display("Operand word consumed while no instruction was pending");
      return;
    end
    cur  = pending_q[0];
    epw  = (`ELEN / 8) >> int'(cur.vsew);
    live = (int'(cur.vl) - issued_elems < epw) ? int'(cur.vl) - issued_elems : epw;
    op_a = cur.use_scalar ? replicate_scalar(cur.scalar_op, cur.vsew) : operand_i[0];
    e.insn  = 16'(insn_idx);
    e.word  = 8'(issued_elems / epw);
    e.id    = cur.id;
    e.addr  = `VADDR_WIDTH'(int'(cur.vd) * `VREG_WORDS + issued_elems / epw);
    e.wdata = expected_word(cur.op, cur.vsew, op_a, operand_i[1], operand_i[2]);
    e.be    = byte_enables(live << int'(cur.vsew));
    e.last  = (issued_elems + live >= int'(cur.vl));
    compare($sformatf("insn%0d_word%0d_readies", insn_idx, e.word),
            {61'd0, cur.op == VMACC, 1'b1, !cur.use_scalar}, {61'd0, operand_ready_i});
    exp_q.push_back(e);
    if (e.last) begin
      void'(pending_q.pop_front());
      issued_elems = 0;
      insn_idx++;
    end else begin
      issued_elems += epw;
    end
  endtask

  task automatic check_write_and_done();
    exp_write_t           e;
    logic [`NR_VINSN-1:0] exp_done;
    string                tag;
    exp_done = '0;
    tag = "idle";
    if (result_req_i && result_gnt_i) begin
      write_count_o++;
      if (exp_q.size() == 0) begin
        error_count_o++;
        $display("Write to address %h granted with no result expected", result_addr_i);
      end else begin
        e = exp_q.pop_front();
        tag = $sformatf("insn%0d_word%0d", e.insn, e.word);
        compare({tag, "_id"}, 64'(e.id), 64'(result_id_i));
        compare({tag, "_addr"}, 64'(e.addr), 64'(result_addr_i));
        compare({tag, "_wdata"}, e.wdata, result_wdata_i);
        compare({tag, "_be"}, 64'(e.be), 64'(result_be_i));
        if (e.last) begin
          exp_done = `NR_VINSN'(1) << e.id;
          in_flight--;
        end
      end
    end
    if (vinsn_done_i != '0) done_count_o++;
    compare({tag, "_done"}, 64'(exp_done), 64'(vinsn_done_i));
  endtask

  // Mid-cycle sampling sees the values the next rising edge will use
  always @(negedge clk_i) begin
    if (rst_ni) begin
      // A queue slot is held from accept until the done pulse
      compare("vinsn_ready", 64'(in_flight < `VINSN_QUEUE_DEPTH), 64'(vinsn_ready_i));
      if (operand_ready_i[1] && operand_valid_i[1]) predict_word();
      if (vinsn_valid_i && vinsn_ready_i) begin
        pending_q.push_back(vinsn_i);
        in_flight++;
      end
      check_write_and_done();
    end
  end

endmodule

// ==== sim/vmul_chk.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_chk import vmul_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [2:0]              operand_valid_i,
  input  logic [2:0]              operand_ready_i,
  input  logic                    result_req_i,
  input  vid_t                    result_id_i,
  input  logic [`VADDR_WIDTH-1:0] result_addr_i,
  input  logic [`ELEN-1:0]        result_wdata_i,
  input  logic [`ELEN/8-1:0]      result_be_i,
  input  logic                    result_gnt_i,
  input  logic [`NR_VINSN-1:0]    vinsn_done_i
);

  int fail_count = 0;

  // A waiting request keeps all of its fields
  req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    result_req_i && !result_gnt_i |=> result_req_i && $stable(result_id_i) &&
      $stable(result_addr_i) && $stable(result_wdata_i) && $stable(result_be_i))
    else begin
      $error("result request changed before its grant");
      fail_count++;
    end

  ready_needs_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (operand_ready_i & ~operand_valid_i) == 3'b000)
    else begin
      $error("operand ready raised without operand valid");
      fail_count++;
    end

  done_onehot_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(vinsn_done_i))
    else begin
      $error("more than one done bit raised in one cycle");
      fail_count++;
    end

endmodule

// ==== verilog/vmul_top.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_top import rvv_pkg::*; import vmul_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vinsn_t                  vinsn_i,
  input  logic                    vinsn_valid_i,
  output logic                    vinsn_ready_o,
  input  logic [2:0][`ELEN-1:0]   operand_i,
  input  logic [2:0]              operand_valid_i,
  output logic [2:0]              operand_ready_o,
  output logic                    result_req_o,
  output vid_t                    result_id_o,
  output logic [`VADDR_WIDTH-1:0] result_addr_o,
  output logic [`ELEN-1:0]        result_wdata_o,
  output logic [`ELEN/8-1:0]      result_be_o,
  input  logic                    result_gnt_i,
  output logic [`NR_VINSN-1:0]    vinsn_done_o
);

  vinsn_t           issue_vinsn, proc_vinsn, commit_vinsn;
  logic             issue_valid, proc_valid, commit_valid;
  logic             issue_done, process_done, commit_done;
  logic             mul_valid, mul_ready;
  logic [`ELEN-1:0] mul_op_a, mul_op_b, mul_op_c;
  vmul_op_e         mul_op;
  vew_e             mul_vsew;
  logic             res_valid, res_ready;
  logic [`ELEN-1:0] res_data;

  vmul_vinsn_queue vmul_vinsn_queue_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .vinsn_i        (vinsn_i),
    .vinsn_valid_i  (vinsn_valid_i),
    .vinsn_ready_o  (vinsn_ready_o),
    .issue_done_i   (issue_done),
    .process_done_i (process_done),
    .commit_done_i  (commit_done),
    .issue_vinsn_o  (issue_vinsn),
    .issue_valid_o  (issue_valid),
    .proc_vinsn_o   (proc_vinsn),
    .proc_valid_o   (proc_valid),
    .commit_vinsn_o (commit_vinsn),
    .commit_valid_o (commit_valid)
  );

  vmul_issue vmul_issue_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .vinsn_i         (issue_vinsn),
    .vinsn_valid_i   (issue_valid),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .mul_ready_i     (mul_ready),
    .mul_valid_o     (mul_valid),
    .mul_op_a_o      (mul_op_a),
    .mul_op_b_o      (mul_op_b),
    .mul_op_c_o      (mul_op_c),
    .mul_op_o        (mul_op),
    .mul_vsew_o      (mul_vsew),
    .issue_done_o    (issue_done)
  );

  vmul_simd_mul vmul_simd_mul_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (mul_valid),
    .ready_o  (mul_ready),
    .op_a_i   (mul_op_a),
    .op_b_i   (mul_op_b),
    .op_c_i   (mul_op_c),
    .op_i     (mul_op),
    .vsew_i   (mul_vsew),
    .valid_o  (res_valid),
    .ready_i  (res_ready),
    .result_o (res_data)
  );

  vmul_commit vmul_commit_inst (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .proc_vinsn_i   (proc_vinsn),
    .proc_valid_i   (proc_valid),
    .commit_vinsn_i (commit_vinsn),
    .commit_valid_i (commit_valid),
    .res_valid_i    (res_valid),
    .res_data_i     (res_data),
    .res_ready_o    (res_ready),
    .process_done_o (process_done),
    .commit_done_o  (commit_done),
    .result_req_o   (result_req_o),
    .result_id_o    (result_id_o),
    .result_addr_o  (result_addr_o),
    .result_wdata_o (result_wdata_o),
    .result_be_o    (result_be_o),
    .result_gnt_i   (result_gnt_i),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

// ==== verilog/vmul_commit.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_commit import vmul_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  vinsn_t                  proc_vinsn_i,
  input  logic                    proc_valid_i,
  input  vinsn_t                  commit_vinsn_i,
  input  logic                    commit_valid_i,
  input  logic                    res_valid_i,
  input  logic [`ELEN-1:0]        res_data_i,
  output logic                    res_ready_o,
  output logic                    process_done_o,
  output logic                    commit_done_o,
  output logic                    result_req_o,
  output vid_t                    result_id_o,
  output logic [`VADDR_WIDTH-1:0] result_addr_o,
  output logic [`ELEN-1:0]        result_wdata_o,
  output logic [`ELEN/8-1:0]      result_be_o,
  input  logic                    result_gnt_i,
  output logic [`NR_VINSN-1:0]    vinsn_done_o
);

  localparam int unsigned VLW        = `VL_WIDTH;
  localparam int unsigned AW         = `VADDR_WIDTH;
  localparam int unsigned WORD_BYTES = `ELEN / 8;
  localparam int unsigned WORD_SHIFT = $clog2(WORD_BYTES);
  localparam int unsigned RQ_DEPTH   = `RESULT_QUEUE_DEPTH;
  localparam int unsigned RQ_PNT_W   = (RQ_DEPTH > 1) ? $clog2(RQ_DEPTH) : 1;
  localparam int unsigned RQ_CNT_W   = $clog2(RQ_DEPTH + 1);

  result_t               rq_q [RQ_DEPTH];
  result_t               entry;
  logic [RQ_PNT_W-1:0]   wr_pnt_q, rd_pnt_q;
  logic [RQ_CNT_W-1:0]   rq_cnt_q;
  logic                  push, pop;

  logic [VLW-1:0]        proc_cnt_q, proc_remaining, proc_epw, proc_live, word_idx;
  logic [WORD_SHIFT:0]   live_bytes;
  logic                  proc_last;

  logic [VLW-1:0]        commit_cnt_q, commit_remaining, commit_epw;
  logic                  commit_busy_q;
  logic                  commit_last;

  function automatic logic [RQ_PNT_W-1:0] next_pnt(input logic [RQ_PNT_W-1:0] pnt);
    return (pnt == RQ_PNT_W'(RQ_DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign res_ready_o = (rq_cnt_q != RQ_CNT_W'(RQ_DEPTH));
  assign push        = res_valid_i && res_ready_o;

  // Processing side counts elements already written into the queue
  assign proc_epw       = VLW'(WORD_BYTES >> proc_vinsn_i.vsew);
  assign proc_remaining = proc_vinsn_i.vl - proc_cnt_q;
  assign proc_last      = (proc_remaining <= proc_epw);
  assign proc_live      = proc_last ? proc_remaining : proc_epw;
  assign live_bytes     = (WORD_SHIFT + 1)'(proc_live << proc_vinsn_i.vsew);
  assign word_idx       = proc_cnt_q >> (WORD_SHIFT - proc_vinsn_i.vsew);
  assign process_done_o = push && proc_valid_i && proc_last;

  always_comb begin
    entry.id    = proc_vinsn_i.id;
    entry.addr  = AW'(proc_vinsn_i.vd * `VREG_WORDS) + AW'(word_idx);
    entry.wdata = res_data_i;
    // Only the live elements of a partial last word are written
    entry.be    = WORD_BYTES'((16'd1 << live_bytes) - 16'd1);
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rq_q[wr_pnt_q] <= entry;
    end
  end

  assign result_req_o   = (rq_cnt_q != '0);
  assign result_id_o    = rq_q[rd_pnt_q].id;
  assign result_addr_o  = rq_q[rd_pnt_q].addr;
  assign result_wdata_o = rq_q[rd_pnt_q].wdata;
  assign result_be_o    = rq_q[rd_pnt_q].be;
  assign pop            = result_req_o && result_gnt_i;

  // Commit side counts down the elements still to be granted
  assign commit_epw       = VLW'(WORD_BYTES >> commit_vinsn_i.vsew);
  assign commit_remaining = commit_busy_q ? commit_cnt_q : commit_vinsn_i.vl;
  assign commit_last      = (commit_remaining <= commit_epw);
  assign commit_done_o    = pop && commit_valid_i && commit_last;
  assign vinsn_done_o     = commit_done_o ? (`NR_VINSN'(1) << commit_vinsn_i.id) : '0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q      <= '0;
      rd_pnt_q      <= '0;
      rq_cnt_q      <= '0;
      proc_cnt_q    <= '0;
      commit_busy_q <= 1'b0;
      commit_cnt_q  <= '0;
    end else begin
      if (push) begin
        wr_pnt_q   <= next_pnt(wr_pnt_q);
        proc_cnt_q <= proc_last ? '0 : proc_cnt_q + proc_epw;
      end
      if (pop) begin
        rd_pnt_q      <= next_pnt(rd_pnt_q);
        commit_busy_q <= !commit_last;
        commit_cnt_q  <= commit_remaining - commit_epw;
      end
      rq_cnt_q <= rq_cnt_q + RQ_CNT_W'(push) - RQ_CNT_W'(pop);
    end
  end

endmodule

// ==== verilog/vmul_simd_mul.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_simd_mul import rvv_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             valid_i,
  output logic             ready_o,
  input  logic [`ELEN-1:0] op_a_i,
  input  logic [`ELEN-1:0] op_b_i,
  input  logic [`ELEN-1:0] op_c_i,
  input  vmul_op_e         op_i,
  input  vew_e             vsew_i,
  output logic             valid_o,
  input  logic             ready_i,
  output logic [`ELEN-1:0] result_o
);

  localparam int unsigned STAGES = `MUL_PIPE_STAGES;

  elem_word_u            a_w, b_w, acc_w, res_w;
  logic signed [15:0]    p16;
  logic signed [31:0]    p32;
  logic signed [63:0]    p64;
  logic signed [127:0]   p128;
  logic [STAGES-1:0]     valid_q;
  logic [`ELEN-1:0]      data_q [STAGES];
  logic                  stall;
  logic                  high;

  assign high = (op_i == VMULH);

  // Signed products give the right low half for VMUL as well
  always_comb begin
    a_w   = op_a_i;
    b_w   = op_b_i;
    acc_w = (op_i == VMACC) ? op_c_i : '0;
    res_w = '0;
    p16   = '0;
    p32   = '0;
    p64   = '0;
    p128  = '0;
    case (vsew_i)
      EW8: begin
        for (int i = 0; i < `ELEN / 8; i++) begin
          p16 = $signed(a_w.w8[i]) * $signed(b_w.w8[i]);
          res_w.w8[i] = high ? p16[15:8] : p16[7:0] + acc_w.w8[i];
        end
      end
      EW16: begin
        for (int i = 0; i < `ELEN / 16; i++) begin
          p32 = $signed(a_w.w16[i]) * $signed(b_w.w16[i]);
          res_w.w16[i] = high ? p32[31:16] : p32[15:0] + acc_w.w16[i];
        end
      end
      EW32: begin
        for (int i = 0; i < `ELEN / 32; i++) begin
          p64 = $signed(a_w.w32[i]) * $signed(b_w.w32[i]);
          res_w.w32[i] = high ? p64[63:32] : p64[31:0] + acc_w.w32[i];
        end
      end
      default: begin
        p128 = $signed(a_w.w64[0]) * $signed(b_w.w64[0]);
        res_w.w64[0] = high ? p128[127:64] : p128[63:0] + acc_w.w64[0];
      end
    endcase
  end

  // The whole pipe holds while the last stage waits
  assign stall   = valid_q[STAGES-1] && !ready_i;
  assign ready_o = !stall;
  assign valid_o = valid_q[STAGES-1];
  assign result_o = data_q[STAGES-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (!stall) begin
      valid_q <= (valid_q << 1) | STAGES'(valid_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      data_q[0] <= res_w;
      for (int s = 1; s < STAGES; s++) begin
        data_q[s] <= data_q[s-1];
      end
    end
  end

endmodule

// ==== verilog/vmul_issue.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_issue import rvv_pkg::*; import vmul_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  vinsn_t                vinsn_i,
  input  logic                  vinsn_valid_i,
  input  logic [2:0][`ELEN-1:0] operand_i,
  input  logic [2:0]            operand_valid_i,
  output logic [2:0]            operand_ready_o,
  input  logic                  mul_ready_i,
  output logic                  mul_valid_o,
  output logic [`ELEN-1:0]      mul_op_a_o,
  output logic [`ELEN-1:0]      mul_op_b_o,
  output logic [`ELEN-1:0]      mul_op_c_o,
  output vmul_op_e              mul_op_o,
  output vew_e                  mul_vsew_o,
  output logic                  issue_done_o
);

  localparam int unsigned VLW        = `VL_WIDTH;
  localparam int unsigned WORD_BYTES = `ELEN / 8;

  elem_word_u        scalar_w;
  logic [2:0]        need;
  logic              fire;
  logic              last_word;
  logic              busy_q;
  logic [VLW-1:0]    cnt_q, remaining, elems_per_word;

  // vs1 unless scalar, vs2 always, vd only to accumulate
  assign need = {vinsn_i.op == VMACC, 1'b1, !vinsn_i.use_scalar};

  always_comb begin
    scalar_w = '0;
    case (vinsn_i.vsew)
      EW8:  for (int i = 0; i < `ELEN / 8; i++) scalar_w.w8[i] = vinsn_i.scalar_op[7:0];
      EW16: for (int i = 0; i < `ELEN / 16; i++) scalar_w.w16[i] = vinsn_i.scalar_op[15:0];
      EW32: for (int i = 0; i < `ELEN / 32; i++) scalar_w.w32[i] = vinsn_i.scalar_op[31:0];
      default: scalar_w.w64[0] = vinsn_i.scalar_op;
    endcase
  end

  assign mul_op_a_o = vinsn_i.use_scalar ? scalar_w : operand_i[0];
  assign mul_op_b_o = operand_i[1];
  assign mul_op_c_o = operand_i[2];
  assign mul_op_o   = vinsn_i.op;
  assign mul_vsew_o = vinsn_i.vsew;

  assign mul_valid_o     = vinsn_valid_i && (&(operand_valid_i | ~need));
  assign fire            = mul_valid_o && mul_ready_i;
  assign operand_ready_o = fire ? need : 3'b000;

  // A fresh instruction starts from its full vector length
  assign elems_per_word = VLW'(WORD_BYTES >> vinsn_i.vsew);
  assign remaining      = busy_q ? cnt_q : vinsn_i.vl;
  assign last_word      = (remaining <= elems_per_word);
  assign issue_done_o   = fire && last_word;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (fire) begin
      busy_q <= !last_word;
      cnt_q  <= remaining - elems_per_word;
    end
  end

endmodule

// ==== verilog/vmul_vinsn_queue.sv ====
`timescale 1ns/1ps
`include "vmul_cfg.svh"

module vmul_vinsn_queue import vmul_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  vinsn_t vinsn_i,
  input  logic   vinsn_valid_i,
  output logic   vinsn_ready_o,
  input  logic   issue_done_i,
  input  logic   process_done_i,
  input  logic   commit_done_i,
  output vinsn_t issue_vinsn_o,
  output logic   issue_valid_o,
  output vinsn_t proc_vinsn_o,
  output logic   proc_valid_o,
  output vinsn_t commit_vinsn_o,
  output logic   commit_valid_o
);

  localparam int unsigned DEPTH = `VINSN_QUEUE_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  vinsn_t             mem_q [DEPTH];
  logic [PNT_W-1:0]   accept_pnt_q, issue_pnt_q, proc_pnt_q, commit_pnt_q;
  logic [CNT_W-1:0]   issue_cnt_q, proc_cnt_q, commit_cnt_q;
  logic               accept;

  function automatic logic [PNT_W-1:0] next_pnt(input logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // A slot stays occupied until its instruction has committed
  assign vinsn_ready_o = (commit_cnt_q != CNT_W'(DEPTH));
  assign accept        = vinsn_valid_i && vinsn_ready_o;

  assign issue_vinsn_o  = mem_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign proc_vinsn_o   = mem_q[proc_pnt_q];
  assign proc_valid_o   = (proc_cnt_q != '0);
  assign commit_vinsn_o = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= vinsn_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      proc_pnt_q   <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      proc_cnt_q   <= '0;
      commit_cnt_q <= '0;
    end else begin
      if (accept) accept_pnt_q <= next_pnt(accept_pnt_q);
      if (issue_done_i) issue_pnt_q <= next_pnt(issue_pnt_q);
      if (process_done_i) proc_pnt_q <= next_pnt(proc_pnt_q);
      if (commit_done_i) commit_pnt_q <= next_pnt(commit_pnt_q);
      // Every phase count goes up on accept and down when its phase ends
      issue_cnt_q  <= issue_cnt_q + CNT_W'(accept) - CNT_W'(issue_done_i);
      proc_cnt_q   <= proc_cnt_q + CNT_W'(accept) - CNT_W'(process_done_i);
      commit_cnt_q <= commit_cnt_q + CNT_W'(accept) - CNT_W'(commit_done_i);
    end
  end

endmodule

// ==== verilog/vmul_pkg.sv ====
`include "vmul_cfg.svh"

package vmul_pkg;

  import rvv_pkg::*;

  typedef logic [$clog2(`NR_VINSN)-1:0] vid_t;

  // Instruction as held in the instruction queue
  typedef struct packed {
    vmul_op_e              op;
    vew_e                  vsew;
    logic [`VL_WIDTH-1:0]  vl;
    logic [4:0]            vd;
    vid_t                  id;
    logic                  use_scalar;
    logic [`ELEN-1:0]      scalar_op;
  } vinsn_t;

  // One pending register file write
  typedef struct packed {
    vid_t                    id;
    logic [`VADDR_WIDTH-1:0] addr;
    logic [`ELEN-1:0]        wdata;
    logic [`ELEN/8-1:0]      be;
  } result_t;

endpackage

// ==== verilog/rvv_pkg.sv ====
`include "vmul_cfg.svh"

package rvv_pkg;

  // Integer multiply operations handled by the unit
  typedef enum logic [1:0] {
    VMUL  = 2'd0,
    VMULH = 2'd1,
    VMACC = 2'd2
  } vmul_op_e;

  // Encoding is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // One data word seen as elements of each width
  typedef union packed {
    logic [`ELEN/8-1:0][7:0]   w8;
    logic [`ELEN/16-1:0][15:0] w16;
    logic [`ELEN/32-1:0][31:0] w32;
    logic [`ELEN/64-1:0][63:0] w64;
  } elem_word_u;

endpackage

// ==== verilog/vmul_cfg.svh ====
`ifndef VMUL_CFG_SVH
`define VMUL_CFG_SVH

// Queue depths
`define VINSN_QUEUE_DEPTH 4
`define RESULT_QUEUE_DEPTH 2

// Multiplier latency in cycles
`define MUL_PIPE_STAGES 2

// Datapath and addressing widths
`define ELEN 64
`define VL_WIDTH 8
`define NR_VINSN 8
`define VADDR_WIDTH 8
`define VREG_WORDS 8

`endif
